//--- src/router_pkg.sv
package router_pkg;

	// message fields
	localparam int ADDR_W = 6;
	localparam int DATA_W = 8;
	localparam int RED_W = 4;

	// one run walks this address range
	localparam int MIN_ADDR = 0;
	localparam int MAX_ADDR = 55;

	// addresses above this go to out1
	localparam int REF_ADDR = 23;

	localparam int DEBOUNCE_CYCLES = 16;
	localparam int CNT_W = 8;

	// debug case codes
	localparam logic [7:0] CASE_CNT0 = 8'h00;
	localparam logic [7:0] CASE_CNT1 = 8'h01;
	localparam logic [7:0] CASE_ERR0 = 8'h02;
	localparam logic [7:0] CASE_ERR1 = 8'h03;
	localparam logic [7:0] CASE_LAST0 = 8'h10;
	localparam logic [7:0] CASE_LAST1 = 8'h11;

	// redundancy nibble sums the data nibbles and the address low nibble
	function automatic logic [RED_W-1:0] calc_red(input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		calc_red = data[7:4] + data[3:0] + addr[3:0];
	endfunction

endpackage

//--- src/switch_debounce.sv
`timescale 1ns/100ps

module switch_debounce
	import router_pkg::*;
(
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_switch,
	output logic o_level,
	output logic o_press,
	output logic o_release
);

	localparam int STABLE_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [STABLE_W-1:0] stable_cnt;
	logic level_q;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			stable_cnt <= '0;
			o_level <= 1'b0;
			level_q <= 1'b0;
		end
		else
		begin
			level_q <= o_level;
			if (i_switch == o_level)
				stable_cnt <= '0;
			else if (stable_cnt == STABLE_W'(DEBOUNCE_CYCLES - 1))
			begin
				// input held long enough, take it
				o_level <= i_switch;
				stable_cnt <= '0;
			end
			else
				stable_cnt <= stable_cnt + 1'b1;
		end
	end

	assign o_press = o_level & ~level_q;
	assign o_release = ~o_level & level_q;

endmodule

//--- src/msg_source.sv
`timescale 1ns/100ps

module msg_source
	import router_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	output logic              o_req,
	output logic [ADDR_W-1:0] o_addr,
	output logic [DATA_W-1:0] o_data,
	output logic [RED_W-1:0]  o_red,
	input  logic              i_ack,
	output logic              o_busy,
	output logic              o_done
);

	logic [ADDR_W-1:0] addr;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			addr <= ADDR_W'(MIN_ADDR);
			o_busy <= 1'b0;
			o_done <= 1'b0;
		end
		else if (!o_busy)
		begin
			// start is ignored while a run is going
			if (i_start)
			begin
				addr <= ADDR_W'(MIN_ADDR);
				o_busy <= 1'b1;
				o_done <= 1'b0;
			end
		end
		else if (i_ack)
		begin
			if (addr == ADDR_W'(MAX_ADDR))
			begin
				o_busy <= 1'b0;
				o_done <= 1'b1;
			end
			else
				addr <= addr + 1'b1;
		end
	end

	// req stays up for the whole run
	assign o_req = o_busy;
	assign o_addr = addr;
	assign o_data = DATA_W'(3 * addr);
	assign o_red = calc_red(addr, o_data);

endmodule

//--- src/route_1to2.sv
`timescale 1ns/100ps

module route_1to2
	import router_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_req,
	input  logic [ADDR_W-1:0] i_addr,
	input  logic [DATA_W-1:0] i_data,
	input  logic [RED_W-1:0]  i_red,
	output logic              o_ack,
	output logic              o_req0,
	output logic [ADDR_W-1:0] o_addr0,
	output logic [DATA_W-1:0] o_data0,
	output logic [RED_W-1:0]  o_red0,
	input  logic              i_ack0,
	output logic              o_req1,
	output logic [ADDR_W-1:0] o_addr1,
	output logic [DATA_W-1:0] o_data1,
	output logic [RED_W-1:0]  o_red1,
	input  logic              i_ack1
);

	logic full;
	logic dest;
	logic [ADDR_W-1:0] slot_addr;
	logic [DATA_W-1:0] slot_data;
	logic [RED_W-1:0] slot_red;
	logic out_ack;

	// ack of the chosen output only
	assign out_ack = dest ? i_ack1 : i_ack0;
	assign o_ack = ~full | out_ack;

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			full <= 1'b0;
		else if (i_req && o_ack)
			full <= 1'b1;
		else if (full && out_ack)
			full <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_req && o_ack)
		begin
			dest <= (i_addr > ADDR_W'(REF_ADDR));
			slot_addr <= i_addr;
			slot_data <= i_data;
			slot_red <= i_red;
		end
	end

	assign o_req0 = full & ~dest;
	assign o_req1 = full & dest;
	assign o_addr0 = slot_addr;
	assign o_data0 = slot_data;
	assign o_red0 = slot_red;
	assign o_addr1 = slot_addr;
	assign o_data1 = slot_data;
	assign o_red1 = slot_red;

endmodule

//--- src/msg_sink.sv
`timescale 1ns/100ps

module msg_sink
	import router_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_hold,
	input  logic              i_req,
	input  logic [ADDR_W-1:0] i_addr,
	input  logic [DATA_W-1:0] i_data,
	input  logic [RED_W-1:0]  i_red,
	output logic              o_ack,
	output logic [CNT_W-1:0]  o_count,
	output logic [CNT_W-1:0]  o_errors,
	output logic [ADDR_W-1:0] o_last_addr
);

	logic xfer;
	logic red_bad;

	// hold stalls the link
	assign o_ack = ~i_hold;
	assign xfer = i_req & o_ack;
	assign red_bad = (calc_red(i_addr, i_data) != i_red);

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			o_count <= '0;
			o_errors <= '0;
			o_last_addr <= '0;
		end
		else if (xfer)
		begin
			o_count <= o_count + 1'b1;
			o_last_addr <= i_addr;
			if (red_bad)
				o_errors <= o_errors + 1'b1;
		end
	end

endmodule

//--- src/debug_select.sv
`timescale 1ns/100ps

module debug_select
	import router_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_hi_release,
	input  logic              i_lo_release,
	input  logic              i_hi_level,
	input  logic              i_lo_level,
	input  logic [CNT_W-1:0]  i_count0,
	input  logic [CNT_W-1:0]  i_errors0,
	input  logic [ADDR_W-1:0] i_last0,
	input  logic [CNT_W-1:0]  i_count1,
	input  logic [CNT_W-1:0]  i_errors1,
	input  logic [ADDR_W-1:0] i_last1,
	output logic [CNT_W-1:0]  o_value,
	output logic [7:0]        o_case_applied
);

	logic [3:0] case_hi;
	logic [3:0] case_lo;
	logic skip_release;
	logic apply;

	// a release with the other button down, or both together
	assign apply = (i_hi_release & i_lo_level) | (i_lo_release & i_hi_level) |
		(i_hi_release & i_lo_release);

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			case_hi <= '0;
			case_lo <= '0;
			skip_release <= 1'b0;
			o_case_applied <= CASE_CNT0;
		end
		else if (i_hi_release || i_lo_release)
		begin
			if (skip_release)
				skip_release <= 1'b0;
			else if (apply)
			begin
				o_case_applied <= {case_hi, case_lo};
				// the other button is still down, drop its release
				skip_release <= ~(i_hi_release & i_lo_release);
			end
			else if (i_hi_release)
				case_hi <= case_hi + 1'b1;
			else
				case_lo <= case_lo + 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_value <= '0;
		else
		begin
			case (o_case_applied)
				CASE_CNT0: o_value <= i_count0;
				CASE_CNT1: o_value <= i_count1;
				CASE_ERR0: o_value <= i_errors0;
				CASE_ERR1: o_value <= i_errors1;
				CASE_LAST0: o_value <= CNT_W'(i_last0);
				CASE_LAST1: o_value <= CNT_W'(i_last1);
				default: o_value <= '0;
			endcase
		end
	end

endmodule

//--- src/seg7_decode.sv
`timescale 1ns/100ps

module seg7_decode
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic [3:0] i_nibble,
	output logic [6:0] o_seg
);

	// bit 6 is segment a, bit 0 is g, low means lit
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			o_seg <= 7'b0000001;
		else
		begin
			case (i_nibble)
				4'h0: o_seg <= 7'b0000001;
				4'h1: o_seg <= 7'b1001111;
				4'h2: o_seg <= 7'b0010010;
				4'h3: o_seg <= 7'b0000110;
				4'h4: o_seg <= 7'b1001100;
				4'h5: o_seg <= 7'b0100100;
				4'h6: o_seg <= 7'b0100000;
				4'h7: o_seg <= 7'b0001111;
				4'h8: o_seg <= 7'b0000000;
				4'h9: o_seg <= 7'b0000100;
				4'ha: o_seg <= 7'b0001000;
				4'hb: o_seg <= 7'b1100000;
				4'hc: o_seg <= 7'b0110001;
				4'hd: o_seg <= 7'b1000010;
				4'he: o_seg <= 7'b0110000;
				default: o_seg <= 7'b0111000;
			endcase
		end
	end

endmodule

//--- src/router_test_top.sv
`timescale 1ns/100ps

module router_test_top
	import router_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_switch_1,
	input  logic       i_switch_2,
	input  logic       i_switch_3,
	input  logic       i_switch_4,
	output logic [6:0] o_segment1,
	output logic [6:0] o_segment2,
	output logic       o_led_1,
	output logic       o_led_2,
	output logic       o_led_3,
	output logic       o_led_4
);

	logic sw1_press;
	logic sw2_press;
	logic sw3_level, sw3_release;
	logic sw4_level, sw4_release;
	logic hold;

	logic src_req, src_ack;
	logic [ADDR_W-1:0] src_addr;
	logic [DATA_W-1:0] src_data;
	logic [RED_W-1:0] src_red;
	logic run_busy, run_done;

	logic req0, ack0, req1, ack1;
	logic [ADDR_W-1:0] addr0, addr1;
	logic [DATA_W-1:0] data0, data1;
	logic [RED_W-1:0] red0, red1;

	logic [CNT_W-1:0] count0, errors0, count1, errors1;
	logic [ADDR_W-1:0] last0, last1;
	logic [CNT_W-1:0] dbg_value;

	switch_debounce u_debounce_1 (.i_clk(i_clk), .i_rst(i_rst), .i_switch(i_switch_1),
		.o_level(), .o_press(sw1_press), .o_release());
	switch_debounce u_debounce_2 (.i_clk(i_clk), .i_rst(i_rst), .i_switch(i_switch_2),
		.o_level(), .o_press(sw2_press), .o_release());
	switch_debounce u_debounce_3 (.i_clk(i_clk), .i_rst(i_rst), .i_switch(i_switch_3),
		.o_level(sw3_level), .o_press(), .o_release(sw3_release));
	switch_debounce u_debounce_4 (.i_clk(i_clk), .i_rst(i_rst), .i_switch(i_switch_4),
		.o_level(sw4_level), .o_press(), .o_release(sw4_release));

	// button 2 toggles back-pressure on both sinks
	always_ff @(posedge i_clk)
	begin
		if (i_rst)
			hold <= 1'b0;
		else if (sw2_press)
			hold <= ~hold;
	end

	msg_source u_msg_source (
		.i_clk(i_clk), .i_rst(i_rst), .i_start(sw1_press),
		.o_req(src_req), .o_addr(src_addr), .o_data(src_data), .o_red(src_red),
		.i_ack(src_ack), .o_busy(run_busy), .o_done(run_done));

	route_1to2 u_route_1to2 (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_req(src_req), .i_addr(src_addr), .i_data(src_data), .i_red(src_red),
		.o_ack(src_ack),
		.o_req0(req0), .o_addr0(addr0), .o_data0(data0), .o_red0(red0), .i_ack0(ack0),
		.o_req1(req1), .o_addr1(addr1), .o_data1(data1), .o_red1(red1), .i_ack1(ack1));

	msg_sink u_sink0 (
		.i_clk(i_clk), .i_rst(i_rst), .i_hold(hold),
		.i_req(req0), .i_addr(addr0), .i_data(data0), .i_red(red0), .o_ack(ack0),
		.o_count(count0), .o_errors(errors0), .o_last_addr(last0));

	msg_sink u_sink1 (
		.i_clk(i_clk), .i_rst(i_rst), .i_hold(hold),
		.i_req(req1), .i_addr(addr1), .i_data(data1), .i_red(red1), .o_ack(ack1),
		.o_count(count1), .o_errors(errors1), .o_last_addr(last1));

	debug_select u_debug_select (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_hi_release(sw3_release), .i_lo_release(sw4_release),
		.i_hi_level(sw3_level), .i_lo_level(sw4_level),
		.i_count0(count0), .i_errors0(errors0), .i_last0(last0),
		.i_count1(count1), .i_errors1(errors1), .i_last1(last1),
		.o_value(dbg_value), .o_case_applied());

	seg7_decode u_seg_hi (.i_clk(i_clk), .i_rst(i_rst), .i_nibble(dbg_value[7:4]),
		.o_seg(o_segment1));
	seg7_decode u_seg_lo (.i_clk(i_clk), .i_rst(i_rst), .i_nibble(dbg_value[3:0]),
		.o_seg(o_segment2));

	assign o_led_1 = run_done;
	assign o_led_2 = run_busy;
	assign o_led_3 = hold;
	assign o_led_4 = (errors0 != '0) | (errors1 != '0);

endmodule

//--- testbench/router_assertions.sv
`timescale 1ns/100ps

module router_assertions
	import router_pkg::*;
(
	input logic              i_clk,
	input logic              i_rst,
	input logic              i_src_req,
	input logic              i_src_ack,
	input logic [ADDR_W-1:0] i_src_addr,
	input logic [DATA_W-1:0] i_src_data,
	input logic [RED_W-1:0]  i_src_red,
	input logic              i_req0,
	input logic              i_ack0,
	input logic [ADDR_W-1:0] i_addr0,
	input logic [DATA_W-1:0] i_data0,
	input logic [RED_W-1:0]  i_red0,
	input logic              i_req1,
	input logic              i_ack1,
	input logic [ADDR_W-1:0] i_addr1,
	input logic [DATA_W-1:0] i_data1,
	input logic [RED_W-1:0]  i_red1,
	input logic              i_led_4
);

	int unsigned fail_count = 0;

	task automatic flag_failure(input string msg);
		$error("%s", msg);
		fail_count++;
	endtask

	// routing by threshold
	route_low: assert property (@(posedge i_clk) disable iff (i_rst)
		i_req0 |-> (i_addr0 <= ADDR_W'(REF_ADDR)))
		else flag_failure("out0 offered an address above the threshold");

	route_high: assert property (@(posedge i_clk) disable iff (i_rst)
		i_req1 |-> (i_addr1 > ADDR_W'(REF_ADDR)))
		else flag_failure("out1 offered an address at or below the threshold");

	// a stalled message keeps req and its fields
	src_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_src_req && !i_src_ack) |=> (i_src_req && $stable(i_src_addr) &&
		$stable(i_src_data) && $stable(i_src_red)))
		else flag_failure("source link changed while stalled");

	out0_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_req0 && !i_ack0) |=> (i_req0 && $stable(i_addr0) && $stable(i_data0) &&
		$stable(i_red0)))
		else flag_failure("out0 link changed while stalled");

	out1_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		(i_req1 && !i_ack1) |=> (i_req1 && $stable(i_addr1) && $stable(i_data1) &&
		$stable(i_red1)))
		else flag_failure("out1 link changed while stalled");

	// data is three times the address
	// low four bits of the full sum give the redundancy nibble
	src_fields: assert property (@(posedge i_clk) disable iff (i_rst)
		i_src_req |-> ((i_src_data == DATA_W'({i_src_addr, 1'b0} + i_src_addr)) &&
		(i_src_red == RED_W'((i_src_data >> 4) + i_src_data + i_src_addr))))
		else flag_failure("source message fields break the data or redundancy rule");

	no_red_errors: assert property (@(posedge i_clk) disable iff (i_rst)
		!i_led_4)
		else flag_failure("a sink counted a redundancy error");

endmodule

//--- testbench/tb_router_test_top.sv
`timescale 1ns/100ps

module tb_router_test_top
	import router_pkg::*;
();

	logic clk;
	logic rst;
	logic sw_1, sw_2, sw_3, sw_4;
	logic [6:0] segment1;
	logic [6:0] segment2;
	logic led_1, led_2, led_3, led_4;

	int check_errors;
	int timeout_errors;
	int assert_errors;
	int pause;
	logic [3:0] pending_hi;
	logic [3:0] pending_lo;

	router_test_top u_router_test_top (
		.i_clk(clk), .i_rst(rst),
		.i_switch_1(sw_1), .i_switch_2(sw_2), .i_switch_3(sw_3), .i_switch_4(sw_4),
		.o_segment1(segment1), .o_segment2(segment2),
		.o_led_1(led_1), .o_led_2(led_2), .o_led_3(led_3), .o_led_4(led_4));

	bind router_test_top router_assertions u_router_assertions (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_src_req(src_req), .i_src_ack(src_ack), .i_src_addr(src_addr),
		.i_src_data(src_data), .i_src_red(src_red),
		.i_req0(req0), .i_ack0(ack0), .i_addr0(addr0), .i_data0(data0), .i_red0(red0),
		.i_req1(req1), .i_ack1(ack1), .i_addr1(addr1), .i_data1(data1), .i_red1(red1),
		.i_led_4(o_led_4));

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic pause_random();
		wait_cycles($urandom_range(20, 4));
	endtask

	// called right after a rising edge
	task automatic set_switch(input int idx, input logic val);
		case (idx)
			1: sw_1 <= val;
			2: sw_2 <= val;
			3: sw_3 <= val;
			default: sw_4 <= val;
		endcase
	endtask

	task automatic press_button(input int idx);
		@(posedge clk);
		set_switch(idx, 1'b1);
		wait_cycles(3 * DEBOUNCE_CYCLES);
		set_switch(idx, 1'b0);
		wait_cycles(3 * DEBOUNCE_CYCLES);
	endtask

	// step the pending nibbles, then hold 3 and release 4 to apply
	task automatic apply_case(input logic [7:0] target);
		logic [3:0] hi_steps;
		logic [3:0] lo_steps;
		hi_steps = target[7:4] - pending_hi;
		lo_steps = target[3:0] - pending_lo;
		for (int i = 0; i < int'(hi_steps); i++)
		begin
			press_button(3);
			pause_random();
		end
		for (int i = 0; i < int'(lo_steps); i++)
		begin
			press_button(4);
			pause_random();
		end
		pending_hi = target[7:4];
		pending_lo = target[3:0];
		@(posedge clk);
		set_switch(3, 1'b1);
		set_switch(4, 1'b1);
		wait_cycles(3 * DEBOUNCE_CYCLES);
		set_switch(4, 1'b0);
		wait_cycles(3 * DEBOUNCE_CYCLES);
		set_switch(3, 1'b0);
		wait_cycles(3 * DEBOUNCE_CYCLES);
	endtask

	// active-low a..g in, hex digit out, -1 for anything else
	function automatic int seg_to_nibble(input logic [6:0] seg);
		logic [6:0] lit;
		lit = ~seg;
		case (lit)
			7'b1111110: return 0;
			7'b0110000: return 1;
			7'b1101101: return 2;
			7'b1111001: return 3;
			7'b0110011: return 4;
			7'b1011011: return 5;
			7'b1011111: return 6;
			7'b1110000: return 7;
			7'b1111111: return 8;
			7'b1111011: return 9;
			7'b1110111: return 10;
			7'b0011111: return 11;
			7'b1001110: return 12;
			7'b0111101: return 13;
			7'b1001111: return 14;
			7'b1000111: return 15;
			default: return -1;
		endcase
	endfunction

	task automatic check_display(input logic [7:0] expected, input string label);
		int hi;
		int lo;
		@(negedge clk);
		hi = seg_to_nibble(segment1);
		lo = seg_to_nibble(segment2);
		if (hi < 0 || lo < 0)
		begin
			$display("CHECK FAILED at %0t: %s segments %b %b are no hex digits", $time,
				label, segment1, segment2);
			check_errors++;
		end
		else if (hi * 16 + lo != int'(expected))
		begin
			$display("CHECK FAILED at %0t: %s shows %02h, expected %02h", $time, label,
				hi * 16 + lo, expected);
			check_errors++;
		end
	endtask

	task automatic check_leds(input logic [3:0] expected, input string label);
		@(negedge clk);
		if ({led_1, led_2, led_3, led_4} != expected)
		begin
			$display("CHECK FAILED at %0t: %s leds %b, expected %b", $time, label,
				{led_1, led_2, led_3, led_4}, expected);
			check_errors++;
		end
	endtask

	// done, not busy, and both router outputs empty
	task automatic wait_run_done(input string label);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!(led_1 && !led_2 && !u_router_test_top.req0 && !u_router_test_top.req1)
			&& cycles < 5000)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!(led_1 && !led_2 && !u_router_test_top.req0 && !u_router_test_top.req1))
		begin
			$display("timeout: %s did not finish within 5000 cycles", label);
			timeout_errors++;
		end
	endtask

	initial
	begin
		rst = 1'b1;
		sw_1 = 1'b0;
		sw_2 = 1'b0;
		sw_3 = 1'b0;
		sw_4 = 1'b0;
		check_errors = 0;
		timeout_errors = 0;
		pending_hi = 4'h0;
		pending_lo = 4'h0;
		void'($urandom(32'h6e762c45));
		wait_cycles(10);
		rst <= 1'b0;
		wait_cycles(2);

		check_leds(4'b0000, "after reset");
		check_display(8'h00, "after reset");

		// run 1 with no back-pressure
		press_button(1);
		wait_run_done("run 1");
		check_leds(4'b1000, "run 1 done");
		apply_case(CASE_CNT0);
		check_display(8'h18, "sink 0 count");
		apply_case(CASE_CNT1);
		check_display(8'h20, "sink 1 count");
		apply_case(CASE_LAST0);
		check_display(8'h17, "sink 0 last address");
		apply_case(CASE_LAST1);
		check_display(8'h37, "sink 1 last address");
		apply_case(CASE_ERR0);
		check_display(8'h00, "sink 0 errors");
		apply_case(CASE_ERR1);
		check_display(8'h00, "sink 1 errors");
		check_leds(4'b1000, "no redundancy errors");

		// run 2, hold comes on partway through the run
		pause = $urandom_range(39, 0);
		fork
			press_button(1);
			begin
				wait_cycles(pause);
				press_button(2);
			end
		join
		check_leds(4'b0110, "run 2 stalled by hold");
		press_button(1);
		check_leds(4'b0110, "start ignored while busy");
		wait_cycles($urandom_range(60, 5));
		press_button(2);
		wait_run_done("run 2");
		check_leds(4'b1000, "run 2 done, hold off");
		apply_case(CASE_CNT0);
		check_display(8'h30, "sink 0 count after two runs");
		apply_case(CASE_CNT1);
		check_display(8'h40, "sink 1 count after two runs");

		apply_case(8'h25);
		check_display(8'h00, "unlisted case");

		assert_errors = int'(u_router_test_top.u_router_assertions.fail_count);
		$display("check errors: %0d, timeouts: %0d, assertion failures: %0d",
			check_errors, timeout_errors, assert_errors);
		if (check_errors == 0 && timeout_errors == 0 && assert_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- files.f
src/router_pkg.sv
src/switch_debounce.sv
src/msg_source.sv
src/route_1to2.sv
src/msg_sink.sv
src/debug_select.sv
src/seg7_decode.sv
src/router_test_top.sv
testbench/router_assertions.sv
testbench/tb_router_test_top.sv

//--- run.sh
#!/bin/sh
# build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_router_test_top \
	--Mdir obj_dir -o tb_sim

# assertion errors must not stop the run early, the testbench counts them
./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
